/* src/issue_params.svh */
// Issue stage configuration
// Thread count, register file size, queue depth and pipeline latencies
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// Hardware threads sharing the issue stage
`define ISSUE_THREADS 4

// Architectural registers per thread
`define ISSUE_NUM_REGS 16

// Entries in each thread queue, which is also the number of credits fetch starts with
`define ISSUE_FIFO_DEPTH 4

// Cycles from issue_valid to the writeback of each pipeline
`define ISSUE_ARITH_LATENCY 1
`define ISSUE_MEM_LATENCY 3

`endif

/* src/issue_pkg.sv */
// Issue stage types
// Thread and register indices, pipeline select, thread state and the instruction word
`include "issue_params.svh"

package issue_pkg;

	typedef logic [$clog2(`ISSUE_THREADS)-1:0] thread_idx_t;
	typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0] reg_idx_t;

	// Which execution pipeline a word goes to, and so which view of the word applies
	typedef enum logic
	{
		PIPE_ARITH = 1'b0,
		PIPE_MEM = 1'b1
	} pipe_t;

	typedef enum logic [1:0]
	{
		TS_EMPTY = 2'd0,
		TS_LATCHED = 2'd1,
		TS_SUSPENDED = 2'd2
	} thread_state_t;

	// Arithmetic form reads two registers and writes one
	typedef struct packed
	{
		reg_idx_t dest;
		reg_idx_t src1;
		reg_idx_t src2;
		logic [3:0] spare;
	} arith_word_t;

	// Memory form: data_reg is the load destination or the store data source
	typedef struct packed
	{
		logic is_store;
		reg_idx_t data_reg;
		reg_idx_t base;
		logic [6:0] offset;
	} mem_word_t;

	// One 16-bit word, decoded by the pipe_t that travels with it
	typedef union packed
	{
		arith_word_t arith;
		mem_word_t mem;
	} issue_word_t;

endpackage

/* src/thread_fifo.sv */
// Per-thread instruction queue
// Circular buffer where every dequeue hands one credit back to fetch
`timescale 1ns/1ns
`include "issue_params.svh"

module thread_fifo import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enq_valid,
	input issue_word_t enq_word,
	input pipe_t enq_pipe,
	input logic dequeue,
	output logic head_valid,
	output issue_word_t head_word,
	output pipe_t head_pipe,
	output logic credit_return
);
	localparam int DEPTH = `ISSUE_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	issue_word_t word_mem[DEPTH];
	pipe_t pipe_mem[DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_deq;

	// Head is visible only from the cycle after its enqueue, since count is registered
	assign head_valid = count != '0;
	assign head_word = word_mem[rd_ptr];
	assign head_pipe = pipe_mem[rd_ptr];
	assign do_deq = dequeue && head_valid;

	// The credit goes back in the same cycle the entry leaves
	assign credit_return = do_deq;

	always_ff @(posedge clk)
	begin
		if (enq_valid)
		begin
			word_mem[wr_ptr] <= enq_word;
			pipe_mem[wr_ptr] <= enq_pipe;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at DEPTH, which need not be a power of two
			if (enq_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_deq)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			// Fetch never sends without a credit, so an enqueue never finds the queue full
			case ({enq_valid, do_deq})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/thread_state_fsm.sv */
// Per-thread issue control
// Latches the queue head, tracks suspend and wake, and decides when the thread is ready
`timescale 1ns/1ns

module thread_state_fsm import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic head_valid,
	input issue_word_t head_word,
	input pipe_t head_pipe,
	input logic enable,
	input logic suspend,
	input logic wake,
	input logic dep_busy,
	input logic conflict_arith,
	input logic conflict_mem,
	input logic granted,
	output logic dequeue,
	output thread_state_t state,
	output issue_word_t latched_word,
	output pipe_t latched_pipe,
	output logic ready
);
	// Latch occupancy, kept apart from state so a suspended thread remembers its word
	logic held;
	logic held_next;
	thread_state_t state_next;
	logic pipe_conflict;
	logic suspend_now;

	// Refill the latch when it is empty or when its word leaves this cycle
	assign dequeue = head_valid && (!held || granted);

	always_comb
	begin
		held_next = held;
		if (dequeue)
			held_next = 1'b1;
		else if (granted)
			held_next = 1'b0;
	end

	// Wake has priority over a suspend arriving in the same cycle
	always_comb
	begin
		if (wake)
			state_next = held_next ? TS_LATCHED : TS_EMPTY;
		else if (suspend || state == TS_SUSPENDED)
			state_next = TS_SUSPENDED;
		else
			state_next = held_next ? TS_LATCHED : TS_EMPTY;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			held <= 1'b0;
			state <= TS_EMPTY;
		end
		else
		begin
			held <= held_next;
			state <= state_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (dequeue)
		begin
			latched_word <= head_word;
			latched_pipe <= head_pipe;
		end
	end

	// Only the slot of the latched word's own pipeline matters
	assign pipe_conflict = (latched_pipe == PIPE_MEM) ? conflict_mem : conflict_arith;

	// A suspend being raised this cycle already holds off the grant
	assign suspend_now = suspend && !wake;

	assign ready = (state == TS_LATCHED) && enable && !dep_busy && !pipe_conflict
		&& !suspend_now;

endmodule

/* src/scoreboard.sv */
// Per-thread register scoreboard
// Tracks registers with a result in flight and flags the latched word if it touches one
`timescale 1ns/1ns
`include "issue_params.svh"

module scoreboard import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input issue_word_t latched_word,
	input pipe_t latched_pipe,
	input logic check_valid,
	input logic granted,
	input logic wb_valid,
	input reg_idx_t wb_reg,
	output logic dep_busy
);
	localparam int NREG = `ISSUE_NUM_REGS;

	logic [NREG-1:0] busy;
	logic [NREG-1:0] dep_bitmap;
	logic [NREG-1:0] dest_bitmap;
	logic [NREG-1:0] clear_bitmap;

	// Decode the word by pipe and store flag into the registers it writes and reads
	always_comb
	begin
		dep_bitmap = '0;
		dest_bitmap = '0;
		if (latched_pipe == PIPE_ARITH)
		begin
			dest_bitmap[latched_word.arith.dest] = 1'b1;
			dep_bitmap[latched_word.arith.src1] = 1'b1;
			dep_bitmap[latched_word.arith.src2] = 1'b1;
		end
		else
		begin
			dep_bitmap[latched_word.mem.base] = 1'b1;
			// Store data is a source, load data a destination
			if (latched_word.mem.is_store)
				dep_bitmap[latched_word.mem.data_reg] = 1'b1;
			else
				dest_bitmap[latched_word.mem.data_reg] = 1'b1;
		end

		// The destination counts too, so a second write waits for the first
		dep_bitmap = dep_bitmap | dest_bitmap;
	end

	always_comb
	begin
		clear_bitmap = '0;
		if (wb_valid)
			clear_bitmap[wb_reg] = 1'b1;
	end

	// A register written back this cycle is already free for the check
	assign dep_busy = check_valid && |(dep_bitmap & busy & ~clear_bitmap);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			busy <= '0;
		else
			busy <= (busy & ~clear_bitmap) | (granted ? dest_bitmap : '0);
	end

endmodule

/* src/writeback_timer.sv */
// Writeback timer for the arithmetic and memory pipelines
// Tracks in-flight slots, emits writebacks at fixed latency and flags slot conflicts
`timescale 1ns/1ns
`include "issue_params.svh"

module writeback_timer import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input pipe_t start_pipe,
	input thread_idx_t start_thread,
	input logic start_has_dest,
	input reg_idx_t start_reg,
	output logic conflict_arith,
	output logic conflict_mem,
	output logic wb_valid,
	output thread_idx_t wb_thread,
	output reg_idx_t wb_reg
);
	localparam int DEPTH = `ISSUE_MEM_LATENCY + 1;
	localparam int SLOT_W = $clog2(DEPTH);
	localparam int ARITH_SLOT = `ISSUE_ARITH_LATENCY;
	localparam int MEM_SLOT = `ISSUE_MEM_LATENCY;

	// Slot 0 is the writeback cycle, slot n is n cycles before it
	logic [DEPTH-1:0] slot_valid;
	logic [DEPTH-1:0] shifted_valid;
	logic [DEPTH-1:0] slot_has_dest;
	thread_idx_t slot_thread[DEPTH];
	reg_idx_t slot_reg[DEPTH];
	logic [SLOT_W-1:0] start_slot;

	// Start comes in the grant cycle, one cycle before issue_valid
	// Writing slot n then puts the writeback n cycles after issue_valid
	assign start_slot = (start_pipe == PIPE_MEM) ? SLOT_W'(MEM_SLOT) : SLOT_W'(ARITH_SLOT);

	// Occupancy as it will be after this cycle's shift
	assign shifted_valid = {1'b0, slot_valid[DEPTH-1:1]};

	// A new word would collide with whatever shifts into its slot
	assign conflict_arith = shifted_valid[ARITH_SLOT];
	assign conflict_mem = shifted_valid[MEM_SLOT];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			slot_valid <= '0;
		else
		begin
			slot_valid <= shifted_valid;
			// Stores take a slot too, even though nothing is written back
			if (start)
				slot_valid[start_slot] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < DEPTH - 1; i++)
		begin
			slot_thread[i] <= slot_thread[i + 1];
			slot_has_dest[i] <= slot_has_dest[i + 1];
			slot_reg[i] <= slot_reg[i + 1];
		end
		if (start)
		begin
			slot_thread[start_slot] <= start_thread;
			slot_has_dest[start_slot] <= start_has_dest;
			slot_reg[start_slot] <= start_reg;
		end
	end

	assign wb_valid = slot_valid[0] && slot_has_dest[0];
	assign wb_thread = slot_thread[0];
	assign wb_reg = slot_reg[0];

endmodule

/* src/issue_arbiter.sv */
// Round-robin issue arbiter
// Grants one ready thread per cycle, starting the search just past the last winner
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_arbiter import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`ISSUE_THREADS-1:0] request,
	output logic [`ISSUE_THREADS-1:0] grant_oh
);
	localparam int N = `ISSUE_THREADS;

	thread_idx_t last_grant;
	thread_idx_t winner;
	thread_idx_t cand;
	logic found;

	// Scan from last_grant + 1 around to last_grant itself
	always_comb
	begin
		grant_oh = '0;
		winner = last_grant;
		found = 1'b0;
		for (int i = 1; i <= N; i++)
		begin
			cand = thread_idx_t'((int'(last_grant) + i) % N);
			if (!found && request[cand])
			begin
				grant_oh[cand] = 1'b1;
				winner = cand;
				found = 1'b1;
			end
		end
	end

	// Thread 0 gets first priority out of reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant <= thread_idx_t'(N - 1);
		else if (found)
			last_grant <= winner;
	end

endmodule

/* src/issue_top.sv */
// Issue stage top level
// Four thread slices feed a round-robin arbiter and a writeback timer, with registered issue
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_top import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enq_valid,
	input thread_idx_t enq_thread,
	input issue_word_t enq_word,
	input pipe_t enq_pipe,
	input logic [`ISSUE_THREADS-1:0] thread_enable,
	input logic [`ISSUE_THREADS-1:0] suspend_oh,
	input logic [`ISSUE_THREADS-1:0] wake_oh,
	output logic [`ISSUE_THREADS-1:0] credit_return,
	output logic issue_valid,
	output thread_idx_t issue_thread,
	output issue_word_t issue_word,
	output pipe_t issue_pipe,
	output logic wb_valid,
	output thread_idx_t wb_thread,
	output reg_idx_t wb_reg
);
	localparam int N = `ISSUE_THREADS;

	logic [N-1:0] head_valid;
	logic [N-1:0] dequeue;
	logic [N-1:0] dep_busy;
	logic [N-1:0] ready;
	logic [N-1:0] grant_oh;
	issue_word_t head_word[N];
	issue_word_t latched_word[N];
	pipe_t head_pipe[N];
	pipe_t latched_pipe[N];
	thread_state_t thread_state[N];
	logic conflict_arith;
	logic conflict_mem;
	logic grant_any;
	thread_idx_t grant_idx;
	issue_word_t grant_word;
	pipe_t grant_pipe;
	logic grant_has_dest;
	reg_idx_t grant_reg;

	genvar t;
	generate
		for (t = 0; t < N; t++)
		begin : thread_gen
			thread_fifo u_fifo
			(
				.clk(clk),
				.reset(reset),
				.enq_valid(enq_valid && enq_thread == thread_idx_t'(t)),
				.enq_word(enq_word),
				.enq_pipe(enq_pipe),
				.dequeue(dequeue[t]),
				.head_valid(head_valid[t]),
				.head_word(head_word[t]),
				.head_pipe(head_pipe[t]),
				.credit_return(credit_return[t])
			);

			// Conflict flags are shared, each slice picks the one for its own pipe
			thread_state_fsm u_fsm
			(
				.clk(clk),
				.reset(reset),
				.head_valid(head_valid[t]),
				.head_word(head_word[t]),
				.head_pipe(head_pipe[t]),
				.enable(thread_enable[t]),
				.suspend(suspend_oh[t]),
				.wake(wake_oh[t]),
				.dep_busy(dep_busy[t]),
				.conflict_arith(conflict_arith),
				.conflict_mem(conflict_mem),
				.granted(grant_oh[t]),
				.dequeue(dequeue[t]),
				.state(thread_state[t]),
				.latched_word(latched_word[t]),
				.latched_pipe(latched_pipe[t]),
				.ready(ready[t])
			);

			// Writebacks are steered to the scoreboard of their own thread
			scoreboard u_sb
			(
				.clk(clk),
				.reset(reset),
				.latched_word(latched_word[t]),
				.latched_pipe(latched_pipe[t]),
				.check_valid(thread_state[t] == TS_LATCHED),
				.granted(grant_oh[t]),
				.wb_valid(wb_valid && wb_thread == thread_idx_t'(t)),
				.wb_reg(wb_reg),
				.dep_busy(dep_busy[t])
			);
		end
	endgenerate

	issue_arbiter u_arb
	(
		.clk(clk),
		.reset(reset),
		.request(ready),
		.grant_oh(grant_oh)
	);

	// One-hot grant to thread index
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < N; i++)
		begin
			if (grant_oh[i])
				grant_idx = thread_idx_t'(i);
		end
	end

	assign grant_any = |grant_oh;
	assign grant_word = latched_word[grant_idx];
	assign grant_pipe = latched_pipe[grant_idx];

	// Only stores lack a destination register
	assign grant_has_dest = (grant_pipe == PIPE_ARITH) || !grant_word.mem.is_store;
	assign grant_reg = (grant_pipe == PIPE_ARITH) ? grant_word.arith.dest
		: grant_word.mem.data_reg;

	writeback_timer u_timer
	(
		.clk(clk),
		.reset(reset),
		.start(grant_any),
		.start_pipe(grant_pipe),
		.start_thread(grant_idx),
		.start_has_dest(grant_has_dest),
		.start_reg(grant_reg),
		.conflict_arith(conflict_arith),
		.conflict_mem(conflict_mem),
		.wb_valid(wb_valid),
		.wb_thread(wb_thread),
		.wb_reg(wb_reg)
	);

	// Issue outputs follow the grant by exactly one cycle
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			issue_valid <= 1'b0;
		else
			issue_valid <= grant_any;
	end

	always_ff @(posedge clk)
	begin
		if (grant_any)
		begin
			issue_thread <= grant_idx;
			issue_word <= grant_word;
			issue_pipe <= grant_pipe;
		end
	end

endmodule

/* verif/issue_asserts.sv */
// Issue stage protocol checks
// Bound into the top level to watch credits, grants, writeback latency and suspend
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_asserts import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enq_valid,
	input thread_idx_t enq_thread,
	input logic [`ISSUE_THREADS-1:0] credit_return,
	input logic [`ISSUE_THREADS-1:0] thread_enable,
	input logic [`ISSUE_THREADS-1:0] suspend_oh,
	input logic [`ISSUE_THREADS-1:0] wake_oh,
	input logic [`ISSUE_THREADS-1:0] grant_oh,
	input logic [`ISSUE_THREADS-1:0] ready,
	input logic issue_valid,
	input thread_idx_t issue_thread,
	input issue_word_t issue_word,
	input pipe_t issue_pipe,
	input logic wb_valid,
	input thread_idx_t wb_thread,
	input reg_idx_t wb_reg
);
	localparam int N = `ISSUE_THREADS;
	localparam int DEPTH = `ISSUE_FIFO_DEPTH;
	localparam int LAT_A = `ISSUE_ARITH_LATENCY;
	localparam int LAT_M = `ISSUE_MEM_LATENCY;

	int fail_count = 0;
	int outstanding[N];
	logic [N-1:0] owed;

	// Words sent to each thread that have not yet earned their credit back
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < N; t++)
				outstanding[t] <= 0;
		end
		else
		begin
			for (int t = 0; t < N; t++)
				outstanding[t] <= outstanding[t]
					+ ((enq_valid && enq_thread == thread_idx_t'(t)) ? 1 : 0)
					- (credit_return[t] ? 1 : 0);
		end
	end

	always_comb
	begin
		for (int t = 0; t < N; t++)
			owed[t] = outstanding[t] != 0;
	end

	a_credit_spend: assert property (@(posedge clk) disable iff (reset)
		enq_valid |-> outstanding[enq_thread] < DEPTH)
	else
	begin
		fail_count++;
		$error("Enqueue to a thread with no credit left");
	end

	a_credit_return: assert property (@(posedge clk) disable iff (reset)
		(credit_return & ~owed) == '0)
	else
	begin
		fail_count++;
		$error("Credit returned for a thread that owes none");
	end

	// At most one grant, and only to a ready thread
	a_grant_ready: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_oh) && (grant_oh & ~ready) == '0)
	else
	begin
		fail_count++;
		$error("Grant not one-hot or given to a thread that is not ready");
	end

	// Disabled threads and threads suspended this cycle get no grant
	a_hold_off: assert property (@(posedge clk) disable iff (reset)
		(grant_oh & (~thread_enable | (suspend_oh & ~wake_oh))) == '0)
	else
	begin
		fail_count++;
		$error("Grant to a disabled or suspending thread");
	end

	a_arith_wb: assert property (@(posedge clk) disable iff (reset)
		$past(issue_valid && issue_pipe == PIPE_ARITH, LAT_A) |-> wb_valid
		&& wb_thread == $past(issue_thread, LAT_A)
		&& wb_reg == $past(issue_word.arith.dest, LAT_A))
	else
	begin
		fail_count++;
		$error("Arithmetic writeback missing or wrong");
	end

	a_load_wb: assert property (@(posedge clk) disable iff (reset)
		$past(issue_valid && issue_pipe == PIPE_MEM && !issue_word.mem.is_store, LAT_M)
		|-> wb_valid && wb_thread == $past(issue_thread, LAT_M)
		&& wb_reg == $past(issue_word.mem.data_reg, LAT_M))
	else
	begin
		fail_count++;
		$error("Load writeback missing or wrong");
	end

	// A store still owns its slot, so nothing else may write back then
	a_store_wb: assert property (@(posedge clk) disable iff (reset)
		$past(issue_valid && issue_pipe == PIPE_MEM && issue_word.mem.is_store, LAT_M)
		|-> !wb_valid)
	else
	begin
		fail_count++;
		$error("Writeback in the slot of a store");
	end

endmodule

bind issue_top issue_asserts u_asserts
(
	.clk(clk),
	.reset(reset),
	.enq_valid(enq_valid),
	.enq_thread(enq_thread),
	.credit_return(credit_return),
	.thread_enable(thread_enable),
	.suspend_oh(suspend_oh),
	.wake_oh(wake_oh),
	.grant_oh(grant_oh),
	.ready(ready),
	.issue_valid(issue_valid),
	.issue_thread(issue_thread),
	.issue_word(issue_word),
	.issue_pipe(issue_pipe),
	.wb_valid(wb_valid),
	.wb_thread(wb_thread),
	.wb_reg(wb_reg)
);

/* verif/issue_tb.sv */
// Issue stage testbench
// Random traffic that respects credits, checked against a reference model of the thread queues
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_tb import issue_pkg::*;
();
	localparam int N = `ISSUE_THREADS;
	localparam int DEPTH = `ISSUE_FIFO_DEPTH;
	localparam int LAT_A = `ISSUE_ARITH_LATENCY;
	localparam int LAT_M = `ISSUE_MEM_LATENCY;
	localparam int RUN_CYCLES = 600;
	localparam int DRAIN_LIMIT = 2000;

	logic clk = 1'b0;
	logic reset;
	logic enq_valid;
	thread_idx_t enq_thread;
	issue_word_t enq_word;
	pipe_t enq_pipe;
	logic [N-1:0] thread_enable;
	logic [N-1:0] suspend_oh;
	logic [N-1:0] wake_oh;
	logic [N-1:0] credit_return;
	logic issue_valid;
	thread_idx_t issue_thread;
	issue_word_t issue_word;
	pipe_t issue_pipe;
	logic wb_valid;
	thread_idx_t wb_thread;
	reg_idx_t wb_reg;

	// Credits held by the sender and the words each thread still owes
	int credits[N];
	issue_word_t exp_word[N][$];
	pipe_t exp_pipe[N][$];
	logic [`ISSUE_NUM_REGS-1:0] busy[N];
	// Pipeline slots that end in a given cycle, indexed by cycle modulo 8
	logic due_valid[8];
	logic due_dest[8];
	thread_idx_t due_thread[8];
	reg_idx_t due_reg[8];
	// Suspend state per thread, and which threads could not be granted last cycle
	logic [N-1:0] susp_model;
	logic [N-1:0] blocked;
	logic set_busy;
	thread_idx_t set_thread;
	reg_idx_t set_reg;
	int cycle;
	int model_errors;
	int timeouts;
	int wait_cycles;

	issue_top dut
	(
		.clk(clk),
		.reset(reset),
		.enq_valid(enq_valid),
		.enq_thread(enq_thread),
		.enq_word(enq_word),
		.enq_pipe(enq_pipe),
		.thread_enable(thread_enable),
		.suspend_oh(suspend_oh),
		.wake_oh(wake_oh),
		.credit_return(credit_return),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_word(issue_word),
		.issue_pipe(issue_pipe),
		.wb_valid(wb_valid),
		.wb_thread(wb_thread),
		.wb_reg(wb_reg)
	);

	always #5 clk = ~clk;

	task automatic report_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		model_errors++;
		$display("** Error %s: expected %h, actual %h", test, expected, actual);
	endtask

	task automatic report_fault(input string msg);
		model_errors++;
		$display("%s", msg);
	endtask

	// Every word leaving must be the oldest one its thread was sent
	task automatic check_issue();
		thread_idx_t t;
		issue_word_t w;
		logic [`ISSUE_NUM_REGS-1:0] touched;
		int lat;
		int slot;
		t = issue_thread;
		w = issue_word;
		touched = '0;
		assert (!blocked[t])
		else
			report_fault($sformatf("Thread %0d issued while suspended or disabled", t));
		if (exp_word[t].size() == 0)
			report_fault($sformatf("Thread %0d issued with nothing enqueued", t));
		else
		begin
			assert (w == exp_word[t][0] && issue_pipe == exp_pipe[t][0])
			else
				report_value("order", {exp_pipe[t][0], exp_word[t][0]}, {issue_pipe, w});
			void'(exp_word[t].pop_front());
			void'(exp_pipe[t].pop_front());
		end
		// An arithmetic word touches dest and both sources
		if (issue_pipe == PIPE_ARITH)
		begin
			touched[w.arith.dest] = 1'b1;
			touched[w.arith.src1] = 1'b1;
			touched[w.arith.src2] = 1'b1;
			set_busy = 1'b1;
			set_reg = w.arith.dest;
			lat = LAT_A;
		end
		else
		begin
			// A memory word touches base and the data register, which only a load writes
			touched[w.mem.base] = 1'b1;
			touched[w.mem.data_reg] = 1'b1;
			set_busy = !w.mem.is_store;
			set_reg = w.mem.data_reg;
			lat = LAT_M;
		end
		set_thread = t;
		assert ((touched & busy[t]) == '0)
		else
			report_value("hazard", 32'd0, 32'(touched & busy[t]));
		slot = (cycle + lat) % 8;
		assert (!due_valid[slot])
		else
			report_fault("Two pipeline slots end in the same cycle");
		due_valid[slot] = 1'b1;
		due_dest[slot] = set_busy;
		due_thread[slot] = t;
		due_reg[slot] = set_reg;
	endtask

	// A writeback appears exactly when a slot with a destination ends
	task automatic check_writeback();
		int slot;
		slot = cycle % 8;
		if (due_valid[slot] && due_dest[slot])
		begin
			assert (wb_valid)
			else
				report_fault($sformatf("Missing writeback for thread %0d", due_thread[slot]));
			if (wb_valid)
			begin
				assert (wb_thread == due_thread[slot] && wb_reg == due_reg[slot])
				else
					report_value("writeback", {due_thread[slot], due_reg[slot]},
						{wb_thread, wb_reg});
			end
		end
		else
		begin
			assert (!wb_valid)
			else
				report_fault("Writeback with no arithmetic word or load due");
		end
		if (wb_valid)
			busy[wb_thread][wb_reg] = 1'b0;
		due_valid[slot] = 1'b0;
	endtask

	// Wake beats a suspend in the same cycle, and a suspended thread stays out until woken
	task automatic update_suspend_model();
		for (int t = 0; t < N; t++)
		begin
			blocked[t] = susp_model[t] || (suspend_oh[t] && !wake_oh[t]) || !thread_enable[t];
			if (wake_oh[t])
				susp_model[t] = 1'b0;
			else if (suspend_oh[t])
				susp_model[t] = 1'b1;
		end
	endtask

	task automatic drive_cycle(input int cyc);
		thread_idx_t t;
		issue_word_t w;
		pipe_t p;
		t = thread_idx_t'($urandom_range(N - 1, 0));
		// Enqueue only while a credit for that thread is in hand
		if ($urandom_range(3, 0) != 0 && credits[t] > 0)
		begin
			w = 16'($urandom());
			p = pipe_t'($urandom_range(1, 0));
			credits[t]--;
			exp_word[t].push_back(w);
			exp_pipe[t].push_back(p);
			enq_valid <= 1'b1;
			enq_thread <= t;
			enq_word <= w;
			enq_pipe <= p;
		end
		else
			enq_valid <= 1'b0;
		if ($urandom_range(15, 0) == 0)
			suspend_oh <= N'(1) << $urandom_range(N - 1, 0);
		else
			suspend_oh <= '0;
		if ($urandom_range(7, 0) == 0)
			wake_oh <= N'($urandom());
		else
			wake_oh <= '0;
		// Thread 2 is switched off for a stretch in the middle of the run
		thread_enable <= (cyc >= 200 && cyc < 350) ? ~(N'(1) << 2) : '1;
	endtask

	function automatic bit drained();
		bit empty;
		empty = 1'b1;
		for (int t = 0; t < N; t++)
		begin
			if (exp_word[t].size() != 0)
				empty = 1'b0;
		end
		for (int s = 0; s < 8; s++)
		begin
			if (due_valid[s])
				empty = 1'b0;
		end
		return empty;
	endfunction

	// Outputs are sampled mid-cycle where they have settled
	always @(negedge clk)
	begin
		if (!reset)
		begin
			set_busy = 1'b0;
			// Hazards are checked before this cycle's writeback frees anything
			if (issue_valid)
				check_issue();
			check_writeback();
			if (set_busy)
				busy[set_thread][set_reg] = 1'b1;
			for (int t = 0; t < N; t++)
			begin
				if (credit_return[t])
					credits[t]++;
				assert (credits[t] <= DEPTH)
				else
					report_fault($sformatf("Thread %0d returned more credits than sent", t));
			end
		end
		update_suspend_model();
		cycle++;
	end

	initial
	begin
		void'($urandom(32'h10bf_0caf));
		reset = 1'b1;
		enq_valid = 1'b0;
		enq_thread = '0;
		enq_word = '0;
		enq_pipe = PIPE_ARITH;
		thread_enable = '1;
		suspend_oh = '0;
		wake_oh = '0;
		cycle = 0;
		model_errors = 0;
		timeouts = 0;
		set_busy = 1'b0;
		susp_model = '0;
		blocked = '0;
		for (int t = 0; t < N; t++)
		begin
			credits[t] = DEPTH;
			busy[t] = '0;
		end
		for (int s = 0; s < 8; s++)
		begin
			due_valid[s] = 1'b0;
			due_dest[s] = 1'b0;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (int cyc = 0; cyc < RUN_CYCLES; cyc++)
		begin
			@(posedge clk);
			drive_cycle(cyc);
		end
		// Stop traffic and release every thread so the queues can empty
		@(posedge clk);
		enq_valid <= 1'b0;
		suspend_oh <= '0;
		wake_oh <= '1;
		thread_enable <= '1;
		wait_cycles = 0;
		while (!drained() && wait_cycles < DRAIN_LIMIT)
		begin
			@(posedge clk);
			wake_oh <= '0;
			wait_cycles++;
		end
		if (!drained())
		begin
			timeouts++;
			$display("Timeout: queues and pipelines did not drain within %0d cycles",
				DRAIN_LIMIT);
		end
		for (int t = 0; t < N; t++)
		begin
			assert (credits[t] == DEPTH)
			else
				report_value("credits", 32'(DEPTH), 32'(credits[t]));
		end
		$display("Errors: model %0d, assertions %0d, timeouts %0d", model_errors,
			dut.u_asserts.fail_count, timeouts);
		if (model_errors == 0 && dut.u_asserts.fail_count == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+src
src/issue_pkg.sv
src/thread_fifo.sv
src/thread_state_fsm.sv
src/scoreboard.sv
src/writeback_timer.sv
src/issue_arbiter.sv
src/issue_top.sv
verif/issue_asserts.sv
verif/issue_tb.sv

/* run.sh */
#!/bin/sh
# Build the issue stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module issue_tb -o issue_sim \
	&& ./obj_dir/issue_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "TB PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
